// File: hdl/biquad_params.svh
// offsets are byte addresses on an 8-bit APB address bus and the FIFO depth must be a power of two
`ifndef BIQUAD_PARAMS_SVH
`define BIQUAD_PARAMS_SVH

// data path
`define BQ_DATA_W      16
`define BQ_COEF_W      16
`define BQ_Q_BITS      14  // coefficient format is Q1.14
`define BQ_ACC_W       40
`define BQ_FIFO_DEPTH  4

// APB3
`define BQ_APB_ADDR_W  8
`define BQ_APB_DATA_W  32

// register map
`define BQ_REG_CTRL    8'h00  // enable, bypass, wave select
`define BQ_REG_PERIOD  8'h04
`define BQ_REG_STEP    8'h08
`define BQ_REG_AMP     8'h0C
`define BQ_REG_B0      8'h10
`define BQ_REG_B1      8'h14
`define BQ_REG_B2      8'h18
`define BQ_REG_A1      8'h1C
`define BQ_REG_A2      8'h20
`define BQ_REG_STATUS  8'h24  // bit 0 sticky overflow, write 1 to clear

`endif

// File: hdl/biquad_pkg.sv
// type widths follow biquad_params.svh and all sample and coefficient types are two's complement
`include "biquad_params.svh"

`default_nettype none

package biquad_pkg;

  typedef logic signed [`BQ_DATA_W-1:0] sample_t;  // audio sample
  typedef logic signed [`BQ_COEF_W-1:0] coef_t;    // fixed point coefficient
  typedef logic signed [`BQ_ACC_W-1:0]  acc_t;     // MAC accumulator

  typedef enum logic {
    WAVE_SAW    = 1'b0,
    WAVE_SQUARE = 1'b1
  } wave_sel_t;

endpackage

`default_nettype wire

// File: hdl/biquad_apb_slave.sv
// APB3 slave with no wait states, registers are 16 bits wide and read back zero extended
`include "biquad_params.svh"

`default_nettype none

module biquad_apb_slave
  import biquad_pkg::*;
(
  input  wire                          clk,
  input  wire                          arst_n,

  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire  [`BQ_APB_ADDR_W-1:0]    paddr,
  input  wire  [`BQ_APB_DATA_W-1:0]    pwdata,
  output logic                         pready,
  output logic [`BQ_APB_DATA_W-1:0]    prdata,

  input  wire                          drop,

  output logic                         enable,
  output logic                         bypass,
  output wave_sel_t                    wave_sel,
  output logic [`BQ_DATA_W-1:0]        period,
  output logic [`BQ_DATA_W-1:0]        step,
  output sample_t                      amp,
  output coef_t                        b0,
  output coef_t                        b1,
  output coef_t                        b2,
  output coef_t                        a1,
  output coef_t                        a2
);

  localparam logic [`BQ_DATA_W-1:0] PERIOD_RST = `BQ_DATA_W'(16);
  localparam coef_t                 B0_RST     = coef_t'(1 << `BQ_Q_BITS);  // unity gain

  logic                      wr_access;
  logic                      overflow;
  logic [`BQ_APB_DATA_W-1:0] rd_data;

  ///////////////////////////////////////////////////////////////////////
  // bus handshake
  ///////////////////////////////////////////////////////////////////////

  assign wr_access = psel && penable && pwrite && pready;

  // pready and read data are set up during the setup phase
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pready <= 1'b0;
      prdata <= '0;
    end else begin
      pready <= psel && !penable;
      if (psel && !penable && !pwrite) begin
        prdata <= rd_data;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (paddr)
      `BQ_REG_CTRL:   rd_data[2:0]            = {wave_sel, bypass, enable};
      `BQ_REG_PERIOD: rd_data[`BQ_DATA_W-1:0] = period;
      `BQ_REG_STEP:   rd_data[`BQ_DATA_W-1:0] = step;
      `BQ_REG_AMP:    rd_data[`BQ_DATA_W-1:0] = amp;
      `BQ_REG_B0:     rd_data[`BQ_COEF_W-1:0] = b0;
      `BQ_REG_B1:     rd_data[`BQ_COEF_W-1:0] = b1;
      `BQ_REG_B2:     rd_data[`BQ_COEF_W-1:0] = b2;
      `BQ_REG_A1:     rd_data[`BQ_COEF_W-1:0] = a1;
      `BQ_REG_A2:     rd_data[`BQ_COEF_W-1:0] = a2;
      `BQ_REG_STATUS: rd_data[0]              = overflow;
      default:        rd_data                 = '0;  // unmapped
    endcase
  end

  ///////////////////////////////////////////////////////////////////////
  // register file
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable   <= 1'b0;
      bypass   <= 1'b0;
      wave_sel <= WAVE_SAW;
      period   <= PERIOD_RST;
      step     <= '0;
      amp      <= '0;
      b0       <= B0_RST;
      b1       <= '0;
      b2       <= '0;
      a1       <= '0;
      a2       <= '0;
    end else if (wr_access) begin
      case (paddr)
        `BQ_REG_CTRL: begin
          enable   <= pwdata[0];
          bypass   <= pwdata[1];
          wave_sel <= wave_sel_t'(pwdata[2]);
        end
        `BQ_REG_PERIOD: period <= pwdata[`BQ_DATA_W-1:0];
        `BQ_REG_STEP:   step   <= pwdata[`BQ_DATA_W-1:0];
        `BQ_REG_AMP:    amp    <= sample_t'(pwdata[`BQ_DATA_W-1:0]);
        `BQ_REG_B0:     b0     <= coef_t'(pwdata[`BQ_COEF_W-1:0]);
        `BQ_REG_B1:     b1     <= coef_t'(pwdata[`BQ_COEF_W-1:0]);
        `BQ_REG_B2:     b2     <= coef_t'(pwdata[`BQ_COEF_W-1:0]);
        `BQ_REG_A1:     a1     <= coef_t'(pwdata[`BQ_COEF_W-1:0]);
        `BQ_REG_A2:     a2     <= coef_t'(pwdata[`BQ_COEF_W-1:0]);
        default: ;
      endcase
    end
  end

  // sticky overflow, a new drop beats a clear in the same cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      overflow <= 1'b0;
    end else if (drop) begin
      overflow <= 1'b1;
    end else if (wr_access && (paddr == `BQ_REG_STATUS) && pwdata[0]) begin
      overflow <= 1'b0;
    end
  end

  // pready only ever rises in the access phase of a selected transfer
  a_pready_in_access : assert property (
    @(posedge clk) disable iff (!arst_n)
    $rose(pready) |-> (psel && penable)
  );

endmodule

`default_nettype wire

// File: hdl/oscillator.sv
// first tick comes period+1 cycles after enable rises, a period of 0 or 1 ticks every cycle
`include "biquad_params.svh"

`default_nettype none

module oscillator
  import biquad_pkg::*;
(
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire                    enable,
  input  wave_sel_t              wave_sel,
  input  wire  [`BQ_DATA_W-1:0]  period,
  input  wire  [`BQ_DATA_W-1:0]  step,
  input  sample_t                amp,
  output logic                   osc_valid,
  output sample_t                osc_sample
);

  logic [`BQ_DATA_W-1:0] tick_cnt;
  logic [`BQ_DATA_W-1:0] phase;
  logic [`BQ_DATA_W-1:0] phase_next;
  logic                  tick;

  function automatic sample_t wave_shape(wave_sel_t sel, logic [`BQ_DATA_W-1:0] ph, sample_t a);
    if (sel == WAVE_SQUARE) begin
      return ph[`BQ_DATA_W-1] ? -a : a;  // top phase bit picks the half period
    end
    return sample_t'(ph);                // sawtooth is the raw phase
  endfunction

  assign tick       = enable && (tick_cnt >= period);
  assign phase_next = phase + step;  // wraps modulo 2^16

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt  <= '0;
      phase     <= '0;
      osc_valid <= 1'b0;
    end else begin
      osc_valid <= tick;  // one cycle per tick
      if (!enable) begin
        tick_cnt <= '0;
        phase    <= '0;
      end else if (tick) begin
        tick_cnt <= `BQ_DATA_W'(1);
        phase    <= phase_next;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // sample is offered the cycle after the tick
  always_ff @(posedge clk) begin
    if (tick) begin
      osc_sample <= wave_shape(wave_sel, phase_next, amp);
    end
  end

endmodule

`default_nettype wire

// File: hdl/sample_fifo.sv
// depth comes from BQ_FIFO_DEPTH and must be a power of two, a sample offered while full is lost
`include "biquad_params.svh"

`default_nettype none

module sample_fifo
  import biquad_pkg::*;
(
  input  wire      clk,
  input  wire      arst_n,

  input  wire      in_valid,
  input  sample_t  in_sample,
  output logic     in_ready,
  output logic     drop,

  output logic     out_valid,
  input  wire      out_ready,
  output sample_t  out_sample
);

  localparam int               DEPTH   = `BQ_FIFO_DEPTH;
  localparam int               PTR_W   = $clog2(DEPTH);
  localparam logic [PTR_W:0]   DEPTH_C = (PTR_W + 1)'(DEPTH);

  sample_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             wr_en;
  logic             rd_en;

  assign in_ready   = (count != DEPTH_C);
  assign out_valid  = (count != '0);
  assign out_sample = mem[rd_ptr];  // stable until popped
  assign wr_en      = in_valid && in_ready;
  assign rd_en      = out_valid && out_ready;
  assign drop       = in_valid && !in_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_sample;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // occupancy stays within the depth and matches the pointer distance
  a_count_in_range : assert property (
    @(posedge clk) disable iff (!arst_n)
    (count <= DEPTH_C) && (count[PTR_W-1:0] == PTR_W'(wr_ptr - rd_ptr))
  );

endmodule

`default_nettype wire

// File: hdl/iir_biquad.sv
// one sample every 7 cycles at most, coefficients and bypass are sampled when a sample is taken
`include "biquad_params.svh"

`default_nettype none

module iir_biquad
  import biquad_pkg::*;
(
  input  wire      clk,
  input  wire      arst_n,

  input  wire      x_valid,
  output logic     x_ready,
  input  sample_t  x,

  output logic     y_valid,
  output sample_t  y,

  input  wire      bypass,
  input  coef_t    b0,
  input  coef_t    b1,
  input  coef_t    b2,
  input  coef_t    a1,
  input  coef_t    a2
);

  localparam acc_t SAT_MAX = acc_t'(2 ** (`BQ_DATA_W - 1) - 1);
  localparam acc_t SAT_MIN = -acc_t'(2 ** (`BQ_DATA_W - 1));

  typedef enum logic [1:0] {
    S_IDLE,
    S_MAC,
    S_OUT
  } state_t;

  state_t  state;
  logic [2:0] mac_idx;
  logic    accept;

  // captured at accept
  sample_t x_q;
  coef_t   b0_q;
  coef_t   b1_q;
  coef_t   b2_q;
  coef_t   a1_q;
  coef_t   a2_q;
  logic    bypass_q;

  // filter history
  sample_t x1;
  sample_t x2;
  sample_t y1;
  sample_t y2;

  coef_t   mul_coef;
  sample_t mul_data;
  logic signed [`BQ_COEF_W+`BQ_DATA_W-1:0] prod;
  acc_t    acc;
  acc_t    acc_shift;
  sample_t y_sat;

  assign accept  = x_valid && x_ready;
  assign x_ready = (state == S_IDLE);
  assign y_valid = (state == S_OUT);
  assign y       = bypass_q ? x_q : y_sat;

  ///////////////////////////////////////////////////////////////////////
  // shared multiplier
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    mul_coef = b0_q;
    mul_data = x_q;
    case (mac_idx)
      3'd1:    {mul_coef, mul_data} = {b1_q, x1};
      3'd2:    {mul_coef, mul_data} = {b2_q, x2};
      3'd3:    {mul_coef, mul_data} = {a1_q, y1};  // feedback terms
      3'd4:    {mul_coef, mul_data} = {a2_q, y2};
      default: ;
    endcase
  end

  assign prod = mul_coef * mul_data;

  always_ff @(posedge clk) begin
    if (accept) begin
      x_q      <= x;
      b0_q     <= b0;
      b1_q     <= b1;
      b2_q     <= b2;
      a1_q     <= a1;
      a2_q     <= a2;
      bypass_q <= bypass;
      acc      <= '0;
    end else if (state == S_MAC) begin
      acc <= (mac_idx >= 3'd3) ? acc - prod : acc + prod;
    end
  end

  // back to Q0 and clamp to the sample range
  always_comb begin
    acc_shift = acc >>> `BQ_Q_BITS;
    if (acc_shift > SAT_MAX) begin
      y_sat = {1'b0, {(`BQ_DATA_W-1){1'b1}}};
    end else if (acc_shift < SAT_MIN) begin
      y_sat = {1'b1, {(`BQ_DATA_W-1){1'b0}}};
    end else begin
      y_sat = acc_shift[`BQ_DATA_W-1:0];
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // sequencing and state update
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= S_IDLE;
      mac_idx <= '0;
      x1      <= '0;
      x2      <= '0;
      y1      <= '0;
      y2      <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          mac_idx <= '0;
          if (accept) state <= S_MAC;
        end
        S_MAC: begin
          mac_idx <= mac_idx + 1'b1;
          if (mac_idx == 3'd4) state <= S_OUT;  // five products done
        end
        S_OUT: begin
          state <= S_IDLE;
          if (!bypass_q) begin
            x2 <= x1;
            x1 <= x_q;
            y2 <= y1;
            y1 <= y_sat;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // busy for six cycles after an accept with the result in the last one
  a_busy_window : assert property (
    @(posedge clk) disable iff (!arst_n)
    accept |=> (!x_ready [*5]) ##1 (!x_ready && y_valid) ##1 x_ready
  );

endmodule

`default_nettype wire

// File: hdl/iir_biquad_system.sv
// single APB3 slave at address 0, the filter output has no back-pressure
`include "biquad_params.svh"

`default_nettype none

module iir_biquad_system
  import biquad_pkg::*;
(
  input  wire                          clk,
  input  wire                          arst_n,

  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire  [`BQ_APB_ADDR_W-1:0]    paddr,
  input  wire  [`BQ_APB_DATA_W-1:0]    pwdata,
  output logic                         pready,
  output logic [`BQ_APB_DATA_W-1:0]    prdata,

  output sample_t                      y,
  output logic                         y_valid
);

  // register outputs
  logic                  enable;
  logic                  bypass;
  wave_sel_t             wave_sel;
  logic [`BQ_DATA_W-1:0] period;
  logic [`BQ_DATA_W-1:0] step;
  sample_t               amp;
  coef_t                 b0;
  coef_t                 b1;
  coef_t                 b2;
  coef_t                 a1;
  coef_t                 a2;

  // oscillator to FIFO
  logic                  osc_valid;
  logic                  osc_ready;
  sample_t               osc_sample;
  logic                  drop;

  // FIFO to filter
  logic                  fifo_valid;
  logic                  fifo_ready;
  sample_t               fifo_sample;

  biquad_apb_slave apb_slave_i0 (
    .clk        ( clk         ), // input
    .arst_n     ( arst_n      ), // input
    .psel       ( psel        ), // input
    .penable    ( penable     ), // input
    .pwrite     ( pwrite      ), // input
    .paddr      ( paddr       ), // input
    .pwdata     ( pwdata      ), // input
    .pready     ( pready      ), // output
    .prdata     ( prdata      ), // output
    .drop       ( drop        ), // input
    .enable     ( enable      ), // output
    .bypass     ( bypass      ), // output
    .wave_sel   ( wave_sel    ), // output
    .period     ( period      ), // output
    .step       ( step        ), // output
    .amp        ( amp         ), // output
    .b0         ( b0          ), // output
    .b1         ( b1          ), // output
    .b2         ( b2          ), // output
    .a1         ( a1          ), // output
    .a2         ( a2          )  // output
  );

  oscillator oscillator_i0 (
    .clk        ( clk         ), // input
    .arst_n     ( arst_n      ), // input
    .enable     ( enable      ), // input
    .wave_sel   ( wave_sel    ), // input
    .period     ( period      ), // input
    .step       ( step        ), // input
    .amp        ( amp         ), // input
    .osc_valid  ( osc_valid   ), // output
    .osc_sample ( osc_sample  )  // output
  );

  sample_fifo sample_fifo_i0 (
    .clk        ( clk         ), // input
    .arst_n     ( arst_n      ), // input
    .in_valid   ( osc_valid   ), // input
    .in_sample  ( osc_sample  ), // input
    .in_ready   ( osc_ready   ), // output
    .drop       ( drop        ), // output
    .out_valid  ( fifo_valid  ), // output
    .out_ready  ( fifo_ready  ), // input
    .out_sample ( fifo_sample )  // output
  );

  iir_biquad iir_biquad_i0 (
    .clk        ( clk         ), // input
    .arst_n     ( arst_n      ), // input
    .x_valid    ( fifo_valid  ), // input
    .x_ready    ( fifo_ready  ), // output
    .x          ( fifo_sample ), // input
    .y_valid    ( y_valid     ), // output
    .y          ( y           ), // output
    .bypass     ( bypass      ), // input
    .b0         ( b0          ), // input
    .b1         ( b1          ), // input
    .b2         ( b2          ), // input
    .a1         ( a1          ), // input
    .a2         ( a2          )  // input
  );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
// free running clock of period 10, reset is held low for 8 cycles at start and again after each request
module tb_clock_gen (
  input  wire rst_req,
  output wire clk,
  output wire arst_n
);

  localparam int HALF_PERIOD = 5;
  localparam int RST_CYCLES  = 8;

  logic clk_q   = 1'b0;
  logic rst_n_q = 1'b0;
  int   low_cnt = 0;

  assign clk    = clk_q;
  assign arst_n = rst_n_q;

  always #HALF_PERIOD clk_q = ~clk_q;

  // reset moves on the falling edge, away from the DUT's sampling edge
  always @(negedge clk_q) begin
    if (rst_req) begin
      rst_n_q <= 1'b0;
      low_cnt <= 0;
    end else if (!rst_n_q) begin
      if (low_cnt == RST_CYCLES - 1) rst_n_q <= 1'b1;
      low_cnt <= low_cnt + 1;
    end
  end

endmodule

// File: dv/tb_iir_biquad_system.sv
// one APB master and a model of oscillator and filter, only the overflow row may drop samples
`include "biquad_params.svh"

module tb_iir_biquad_system
  import biquad_pkg::*;
();

  localparam int          NUM_ROWS   = 7;
  localparam int          APB_LIMIT  = 8;
  localparam int          Y_LIMIT    = 400;
  localparam int          RST_LIMIT  = 40;
  localparam int          POLL_LIMIT = 40;
  localparam int          MAX_GAP    = 120;  // cycles between y_valid pulses
  localparam logic [31:0] SEED       = 32'hdd08f247;

  typedef struct {
    wave_sel_t wave;
    int        period;
    int        step;
    int        amp;
    logic      bypass;
    int        b0;
    int        b1;
    int        b2;
    int        a1;
    int        a2;
    int        n_out;
    logic      ovf_test;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        rst_req;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic        pready;
  logic [31:0] prdata;
  sample_t     y;
  logic        y_valid;

  row_t rows [NUM_ROWS];
  int   errors;
  int   timeouts;
  int   sat_hi;
  int   sat_lo;
  int   hx1;  // model history
  int   hx2;
  int   hy1;
  int   hy2;
  logic watch_gap;
  int   gap     = 0;
  int   max_gap = 0;

  tb_clock_gen clk_gen0 (
    .rst_req ( rst_req ),
    .clk     ( clk     ),
    .arst_n  ( arst_n  )
  );

  iir_biquad_system dut0 (
    .clk     ( clk     ),
    .arst_n  ( arst_n  ),
    .psel    ( psel    ),
    .penable ( penable ),
    .pwrite  ( pwrite  ),
    .paddr   ( paddr   ),
    .pwdata  ( pwdata  ),
    .pready  ( pready  ),
    .prdata  ( prdata  ),
    .y       ( y       ),
    .y_valid ( y_valid )
  );

  // longest stretch without an output while watched
  always @(negedge clk) begin
    if (!watch_gap || y_valid) gap <= 0;
    else gap <= gap + 1;
    if (!watch_gap) max_gap <= 0;
    else if (gap > max_gap) max_gap <= gap;
  end

  ///////////////////////////////////////////////////////////////////////
  // reference model
  ///////////////////////////////////////////////////////////////////////

  function automatic int osc_model(wave_sel_t wave, int k, int step, int amp);
    logic [15:0] ph;
    ph = 16'(k * step);  // phase after the k-th tick
    if (wave == WAVE_SQUARE) return ph[15] ? -amp : amp;
    return int'($signed(ph));
  endfunction

  function automatic int biquad_model(row_t r, int x);
    longint acc;
    longint q;
    int     yv;
    acc = longint'(r.b0) * x + longint'(r.b1) * hx1 + longint'(r.b2) * hx2
          - longint'(r.a1) * hy1 - longint'(r.a2) * hy2;
    q = acc >>> `BQ_Q_BITS;
    if (q > 32767) yv = 32767;
    else if (q < -32768) yv = -32768;
    else yv = int'(q);
    hx2 = hx1;
    hx1 = x;
    hy2 = hy1;
    hy1 = yv;
    return yv;
  endfunction

  task automatic fill_table();
    int s0;
    int s2;
    int s4;
    int s6;
    s0 = $urandom_range(65535, 1);
    s2 = $urandom_range(65535, 1);
    s4 = $urandom_range(65535, 1);
    s6 = $urandom_range(65535, 1);
    // wave, period, step, amp, bypass, b0, b1, b2, a1, a2, outputs, overflow row
    rows[0] = '{WAVE_SAW,    10, s0,    0,     1'b1, 16384, 0,      0,    0,      0,    12, 1'b0};
    rows[1] = '{WAVE_SQUARE, 12, 6144,  4660,  1'b1, 16384, 0,      0,    0,      0,    12, 1'b0};
    rows[2] = '{WAVE_SAW,    10, s2,    0,     1'b0, 8192,  4096,   2048, -4096,  1024, 16, 1'b0};
    rows[3] = '{WAVE_SQUARE, 9,  8192,  8192,  1'b0, 4096,  4096,   4096, -8192,  2048, 16, 1'b0};
    rows[4] = '{WAVE_SAW,    8,  s4,    0,     1'b0, 16384, -16384, 0,    -12288, 6144, 16, 1'b0};
    rows[5] = '{WAVE_SQUARE, 8,  16384, 32767, 1'b0, 32767, 32767,  0,    0,      0,    12, 1'b0};
    rows[6] = '{WAVE_SAW,    2,  s6,    0,     1'b1, 16384, 0,      0,    0,      0,    0,  1'b1};
  endtask

  ///////////////////////////////////////////////////////////////////////
  // bus and wait helpers
  ///////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input int got, input int exp);
    errors++;
    $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
  endtask

  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    rdata = '0;
    if (timeouts != 0) return;
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    n = 0;
    while (!pready && n < APB_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (pready) begin
      rdata = prdata;
      if (n != 0) begin
        errors++;
        $display("** Error @ %0t: pready came after %0d wait states", $time, n);
      end
    end else begin
      $display("APB transfer to address 0x%02h got no pready", addr);
      timeouts++;
    end
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'd0, data);
  endtask

  task automatic read_expect(input string what, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    apb_read(addr, rd);
    if (timeouts == 0 && rd != exp) report_mismatch(what, rd, exp);
  endtask

  task automatic write_readback(input string what, input logic [7:0] addr,
                                input logic [31:0] data);
    apb_write(addr, data);
    read_expect(what, addr, data);
  endtask

  task automatic wait_y(output logic ok);
    int n;
    ok = 1'b0;
    if (timeouts != 0) return;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!y_valid && n < Y_LIMIT);
    if (y_valid) begin
      ok = 1'b1;
    end else begin
      $display("no y_valid pulse within %0d cycles", Y_LIMIT);
      timeouts++;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (arst_n !== 1'b1 && n < RST_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (arst_n !== 1'b1) begin
      $display("reset was not released within %0d cycles", RST_LIMIT);
      timeouts++;
    end
  endtask

  task automatic apply_reset();
    int n;
    rst_req = 1'b1;
    n = 0;
    while (arst_n && n < RST_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    rst_req = 1'b0;
    if (arst_n) begin
      $display("reset request was not taken by the clock generator");
      timeouts++;
      return;
    end
    wait_reset_release();
  endtask

  task automatic poll_overflow(output logic [31:0] st);
    int n;
    n = 0;
    st = '0;
    do begin
      apb_read(`BQ_REG_STATUS, st);
      n++;
    end while (st[0] == 1'b0 && n < POLL_LIMIT && timeouts == 0);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // test sequences
  ///////////////////////////////////////////////////////////////////////

  task automatic check_reset_values();
    read_expect("CTRL after reset", `BQ_REG_CTRL, 0);
    read_expect("PERIOD after reset", `BQ_REG_PERIOD, 16);
    read_expect("STEP after reset", `BQ_REG_STEP, 0);
    read_expect("AMP after reset", `BQ_REG_AMP, 0);
    read_expect("B0 after reset", `BQ_REG_B0, 32'h4000);  // unity in Q1.14
    read_expect("B1 after reset", `BQ_REG_B1, 0);
    read_expect("B2 after reset", `BQ_REG_B2, 0);
    read_expect("A1 after reset", `BQ_REG_A1, 0);
    read_expect("A2 after reset", `BQ_REG_A2, 0);
    read_expect("STATUS after reset", `BQ_REG_STATUS, 0);
    read_expect("unmapped 0x28", 8'h28, 0);
    read_expect("unmapped 0xFC", 8'hFC, 0);
  endtask

  task automatic program_row(input row_t r);
    write_readback("PERIOD", `BQ_REG_PERIOD, r.period);
    write_readback("STEP", `BQ_REG_STEP, r.step);
    write_readback("AMP", `BQ_REG_AMP, r.amp & 32'hFFFF);
    write_readback("B0", `BQ_REG_B0, r.b0 & 32'hFFFF);
    write_readback("B1", `BQ_REG_B1, r.b1 & 32'hFFFF);
    write_readback("B2", `BQ_REG_B2, r.b2 & 32'hFFFF);
    write_readback("A1", `BQ_REG_A1, r.a1 & 32'hFFFF);
    write_readback("A2", `BQ_REG_A2, r.a2 & 32'hFFFF);
    write_readback("CTRL", `BQ_REG_CTRL, {29'd0, r.wave, r.bypass, 1'b1});  // enable last
  endtask

  task automatic overflow_test();
    logic [31:0] st;
    logic        ok;
    watch_gap = 1'b1;
    poll_overflow(st);
    if (timeouts == 0 && st[0] != 1'b1) report_mismatch("STATUS after drops", st, 1);
    apb_write(`BQ_REG_PERIOD, 100);  // slower than the filter, drops stop
    wait_y(ok);
    wait_y(ok);
    apb_write(`BQ_REG_STATUS, 1);
    read_expect("STATUS after clear", `BQ_REG_STATUS, 0);
    apb_write(`BQ_REG_PERIOD, 2);
    poll_overflow(st);
    if (timeouts == 0 && st[0] != 1'b1) report_mismatch("STATUS after new drops", st, 1);
    wait_y(ok);
    if (timeouts == 0 && max_gap > MAX_GAP) begin
      errors++;
      $display("** Error @ %0t: y_valid paused for %0d cycles", $time, max_gap);
    end
    watch_gap = 1'b0;
  endtask

  task automatic run_row(input int idx);
    row_t r;
    logic ok;
    int   x;
    int   exp_y;
    int   got;
    r = rows[idx];
    apply_reset();  // clears the filter history
    hx1 = 0;
    hx2 = 0;
    hy1 = 0;
    hy2 = 0;
    program_row(r);
    if (r.ovf_test) begin
      overflow_test();
    end else begin
      for (int k = 1; k <= r.n_out; k++) begin
        wait_y(ok);
        if (!ok) break;
        x = osc_model(r.wave, k, r.step, r.amp);
        if (r.bypass) exp_y = x;
        else exp_y = biquad_model(r, x);
        got = int'(y);
        if (got != exp_y) report_mismatch($sformatf("row %0d output %0d", idx, k), got, exp_y);
        if (!r.bypass && got == 32767) sat_hi++;
        if (!r.bypass && got == -32768) sat_lo++;
      end
      read_expect("STATUS without drops", `BQ_REG_STATUS, 0);
    end
  endtask

  initial begin
    rst_req   = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    errors    = 0;
    timeouts  = 0;
    sat_hi    = 0;
    sat_lo    = 0;
    watch_gap = 1'b0;
    void'($urandom(SEED));
    fill_table();
    wait_reset_release();
    check_reset_values();
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (timeouts == 0) run_row(i);
    end
    if (timeouts == 0 && (sat_hi == 0 || sat_lo == 0)) begin
      errors++;
      $display("** Error @ %0t: saturation limits were not both reached", $time);
    end
    $display("summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+hdl
hdl/biquad_pkg.sv
hdl/biquad_apb_slave.sv
hdl/oscillator.sv
hdl/sample_fifo.sv
hdl/iir_biquad.sv
hdl/iir_biquad_system.sv
dv/tb_clock_gen.sv
dv/tb_iir_biquad_system.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status follows the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_iir_biquad_system -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
